// ==== common/tlp_pkg.sv ====
`default_nettype none

package tlp_pkg;

	// ------------------------------
	// Field types
	// ------------------------------
	typedef logic [15:0] data16_t;
	typedef logic [9:0]  tlp_len_t;
	typedef logic [3:0]  byte_en_t;
	typedef logic [11:0] bcount_t;
	typedef logic [15:0] req_id_t;
	typedef logic [7:0]  tag_t;
	typedef logic [6:0]  bar_hit_t;
	typedef logic [6:0]  low_addr_t;
	typedef logic [7:0]  pd_num_t;

	// Command class taken from the type field
	typedef enum logic [2:0] {
		MEM,
		MEM_LOCK,
		IO,
		CFG0,
		CFG1,
		MSG,
		CPL,
		CPL_LOCK
	} tlp_kind_e;

	// ------------------------------
	// State machines
	// ------------------------------
	typedef enum logic [3:0] {
		RX_HEAD0,
		RX_HEAD1,
		RX_REQID,
		RX_TAG,
		RX_ADDR_HI0,
		RX_ADDR_HI1,
		RX_ADDR_MID,
		RX_ADDR_LO,
		RX_PAYLOAD,
		RX_SKIP
	} rx_state_e;

	typedef enum logic [2:0] {
		SLV_IDLE,
		SLV_WRITE,
		SLV_READ
	} slv_state_e;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_WAIT,
		TX_HDR,
		TX_PAY
	} tx_state_e;

	// 3DW header with data, completion with data
	localparam logic [1:0] CPL_FMT  = 2'b10;
	localparam logic [4:0] CPL_TYPE = 5'b01010;

endpackage

`default_nettype wire

// ==== rx/tlp_rx_parser.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlp_rx_parser (
	input  wire                  pcie_clk,
	input  wire                  sys_rst,
	input  wire                  rx_st_i,
	input  wire                  rx_end_i,
	input  wire tlp_pkg::data16_t rx_data_i,
	output logic                 hdr_valid_o,
	output tlp_pkg::tlp_kind_e   kind_o,
	output logic                 has_data_o,
	output logic                 addr64_o,
	output tlp_pkg::tlp_len_t    length_o,
	output tlp_pkg::req_id_t     req_id_o,
	output tlp_pkg::tag_t        tag_o,
	output tlp_pkg::byte_en_t    first_be_o,
	output tlp_pkg::byte_en_t    last_be_o,
	output logic [29:0]          addr_o,
	output logic                 pay_valid_o,
	output tlp_pkg::data16_t     pay_data_o,
	output logic                 pay_end_o
);

	tlp_pkg::rx_state_e state;

	function automatic tlp_pkg::tlp_kind_e classify(input logic [4:0] typ);
		tlp_pkg::tlp_kind_e kind;
		if (typ[4]) begin
			kind = tlp_pkg::MSG;
		end else if (!typ[3]) begin
			case (typ[2:0])
				3'b000:  kind = tlp_pkg::MEM;
				3'b001:  kind = tlp_pkg::MEM_LOCK;
				3'b010:  kind = tlp_pkg::IO;
				3'b100:  kind = tlp_pkg::CFG0;
				default: kind = tlp_pkg::CFG1;
			endcase
		end else begin
			kind = typ[0] ? tlp_pkg::CPL_LOCK : tlp_pkg::CPL;
		end
		return kind;
	endfunction

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state       <= tlp_pkg::RX_HEAD0;
			hdr_valid_o <= 1'b0;
			pay_valid_o <= 1'b0;
			pay_end_o   <= 1'b0;
		end else begin
			hdr_valid_o <= 1'b0;
			pay_valid_o <= 1'b0;
			pay_end_o   <= 1'b0;
			case (state)
				tlp_pkg::RX_HEAD0: begin
					if (rx_st_i) begin
						kind_o     <= classify(rx_data_i[12:8]);
						has_data_o <= rx_data_i[14];
						addr64_o   <= rx_data_i[13];
						state      <= tlp_pkg::RX_HEAD1;
					end
				end
				tlp_pkg::RX_HEAD1: begin
					length_o <= rx_data_i[9:0];
					// Received completions only need their credits
					if (kind_o == tlp_pkg::CPL || kind_o == tlp_pkg::CPL_LOCK)
						state <= tlp_pkg::RX_SKIP;
					else
						state <= tlp_pkg::RX_REQID;
				end
				tlp_pkg::RX_REQID: begin
					req_id_o <= rx_data_i;
					state    <= tlp_pkg::RX_TAG;
				end
				tlp_pkg::RX_TAG: begin
					tag_o      <= rx_data_i[15:8];
					last_be_o  <= rx_data_i[7:4];
					first_be_o <= rx_data_i[3:0];
					state      <= addr64_o ? tlp_pkg::RX_ADDR_HI0 : tlp_pkg::RX_ADDR_MID;
				end
				// Upper address bits are not decoded
				tlp_pkg::RX_ADDR_HI0: state <= tlp_pkg::RX_ADDR_HI1;
				tlp_pkg::RX_ADDR_HI1: state <= tlp_pkg::RX_ADDR_MID;
				tlp_pkg::RX_ADDR_MID: begin
					addr_o[29:14] <= rx_data_i;
					state         <= tlp_pkg::RX_ADDR_LO;
				end
				tlp_pkg::RX_ADDR_LO: begin
					addr_o[13:0] <= rx_data_i[15:2];
					hdr_valid_o  <= 1'b1;
					state        <= tlp_pkg::RX_PAYLOAD;
				end
				tlp_pkg::RX_PAYLOAD: begin
					pay_valid_o <= 1'b1;
					pay_data_o  <= rx_data_i;
					pay_end_o   <= rx_end_i;
				end
				tlp_pkg::RX_SKIP: begin
				end
				default: state <= tlp_pkg::RX_HEAD0;
			endcase
			if (rx_end_i)
				state <= tlp_pkg::RX_HEAD0;
		end
	end

endmodule

`default_nettype wire

// ==== rx/tlp_rx_credit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlp_rx_credit (
	input  wire                     pcie_clk,
	input  wire                     sys_rst,
	input  wire                     rx_end_i,
	input  wire tlp_pkg::bar_hit_t  rx_bar_hit_i,
	input  wire tlp_pkg::tlp_kind_e kind_i,
	input  wire                     has_data_i,
	input  wire tlp_pkg::tlp_len_t  length_i,
	output logic                    ph_cr_o,
	output logic                    pd_cr_o,
	output logic                    nph_cr_o,
	output logic                    npd_cr_o,
	output tlp_pkg::pd_num_t        pd_num_o
);

	tlp_pkg::pd_num_t data_cr;

	// One data credit covers four doublewords
	assign data_cr = length_i[9:2] + {7'b0, |length_i[1:0]};

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			ph_cr_o  <= 1'b0;
			pd_cr_o  <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			pd_num_o <= '0;
		end else begin
			ph_cr_o  <= 1'b0;
			pd_cr_o  <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			pd_num_o <= '0;
			if (rx_end_i) begin
				case (kind_i)
					tlp_pkg::MEM, tlp_pkg::MEM_LOCK: begin
						if (rx_bar_hit_i != '0) begin
							if (has_data_i) begin
								ph_cr_o  <= 1'b1;
								pd_cr_o  <= 1'b1;
								pd_num_o <= data_cr;
							end else begin
								nph_cr_o <= 1'b1;
							end
						end
					end
					tlp_pkg::IO, tlp_pkg::CFG0, tlp_pkg::CFG1: begin
						nph_cr_o <= 1'b1;
						npd_cr_o <= has_data_i;
					end
					tlp_pkg::MSG: begin
						ph_cr_o <= 1'b1;
						if (has_data_i) begin
							pd_cr_o  <= 1'b1;
							pd_num_o <= data_cr;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/slv_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module slv_sequencer #(
	parameter int SLV_ADR_W = 19
) (
	input  wire                     pcie_clk,
	input  wire                     sys_rst,
	input  wire                     hdr_valid_i,
	input  wire tlp_pkg::tlp_kind_e kind_i,
	input  wire                     has_data_i,
	input  wire tlp_pkg::tlp_len_t  length_i,
	input  wire tlp_pkg::req_id_t   req_id_i,
	input  wire tlp_pkg::tag_t      tag_i,
	input  wire tlp_pkg::byte_en_t  first_be_i,
	input  wire tlp_pkg::byte_en_t  last_be_i,
	input  wire [29:0]              addr_i,
	input  wire                     pay_valid_i,
	input  wire tlp_pkg::data16_t   pay_data_i,
	input  wire                     pay_end_i,
	input  wire tlp_pkg::bar_hit_t  rx_bar_hit_i,
	input  wire                     pay_req_i,
	input  wire                     cpl_done_i,
	output tlp_pkg::bar_hit_t       slv_bar_o,
	output logic                    slv_ce_o,
	output logic                    slv_we_o,
	output logic [SLV_ADR_W-1:0]    slv_adr_o,
	output tlp_pkg::data16_t        slv_dat_o,
	output logic [1:0]              slv_sel_o,
	output logic                    cpl_valid_o,
	output tlp_pkg::tlp_len_t       cpl_len_o,
	output tlp_pkg::bcount_t        bcount_o,
	output tlp_pkg::req_id_t        cpl_req_id_o,
	output tlp_pkg::tag_t           cpl_tag_o,
	output tlp_pkg::low_addr_t      low_addr_o
);

	tlp_pkg::slv_state_e   state;
	tlp_pkg::bar_hit_t     bar_q;
	logic [SLV_ADR_W-1:0]  adr_q;
	logic [10:0]           wcnt;
	tlp_pkg::tlp_len_t     dw_last;
	tlp_pkg::bcount_t      rd_bcount;
	logic                  mem_hit;

	function automatic logic [1:0] lo_idx(input tlp_pkg::byte_en_t be);
		casez (be)
			4'b???1: return 2'd0;
			4'b??10: return 2'd1;
			4'b?100: return 2'd2;
			4'b1000: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	function automatic logic [1:0] hi_idx(input tlp_pkg::byte_en_t be);
		casez (be)
			4'b1???: return 2'd3;
			4'b01??: return 2'd2;
			4'b001?: return 2'd1;
			default: return 2'd0;
		endcase
	endfunction

	// Bar hit seen with the last address halfword
	always_ff @(posedge pcie_clk)
		bar_q <= rx_bar_hit_i;

	assign mem_hit = hdr_valid_i && kind_i == tlp_pkg::MEM && bar_q != '0;
	assign dw_last = length_i - 10'd1;

	always_comb begin
		if (length_i == 10'd1) begin
			if (first_be_i == '0)
				rd_bcount = 12'd1;
			else
				rd_bcount = {10'b0, hi_idx(first_be_i) - lo_idx(first_be_i)} + 12'd1;
		end else begin
			rd_bcount = {length_i, 2'b00} - {10'b0, lo_idx(first_be_i)}
				- {10'b0, 2'd3 - hi_idx(last_be_i)};
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state       <= tlp_pkg::SLV_IDLE;
			slv_bar_o   <= '0;
			slv_ce_o    <= 1'b0;
			slv_we_o    <= 1'b0;
			cpl_valid_o <= 1'b0;
		end else begin
			slv_ce_o <= 1'b0;
			slv_we_o <= 1'b0;
			case (state)
				tlp_pkg::SLV_IDLE: begin
					slv_bar_o <= '0;
					if (mem_hit) begin
						slv_bar_o <= bar_q;
						adr_q     <= {addr_i[SLV_ADR_W-2:0], 1'b0};
						wcnt      <= '0;
						if (has_data_i) begin
							state <= tlp_pkg::SLV_WRITE;
						end else begin
							cpl_len_o    <= length_i;
							bcount_o     <= rd_bcount;
							cpl_req_id_o <= req_id_i;
							cpl_tag_o    <= tag_i;
							low_addr_o   <= {addr_i[4:0], lo_idx(first_be_i)};
							cpl_valid_o  <= 1'b1;
							state        <= tlp_pkg::SLV_READ;
						end
					end
				end
				tlp_pkg::SLV_WRITE: begin
					if (pay_valid_i) begin
						slv_ce_o  <= 1'b1;
						slv_we_o  <= 1'b1;
						slv_adr_o <= adr_q;
						slv_dat_o <= pay_data_i;
						adr_q     <= adr_q + 1'b1;
						wcnt      <= wcnt + 11'd1;
						// Upper byte of the halfword is the lower address
						if (wcnt[10:1] == '0)
							slv_sel_o <= wcnt[0] ? {first_be_i[2], first_be_i[3]}
								: {first_be_i[0], first_be_i[1]};
						else if (wcnt[10:1] == dw_last)
							slv_sel_o <= wcnt[0] ? {last_be_i[2], last_be_i[3]}
								: {last_be_i[0], last_be_i[1]};
						else
							slv_sel_o <= 2'b11;
						if (pay_end_i)
							state <= tlp_pkg::SLV_IDLE;
					end
				end
				tlp_pkg::SLV_READ: begin
					if (pay_req_i) begin
						slv_ce_o  <= 1'b1;
						slv_adr_o <= adr_q;
						adr_q     <= adr_q + 1'b1;
					end
					if (cpl_done_i) begin
						cpl_valid_o <= 1'b0;
						state       <= tlp_pkg::SLV_IDLE;
					end
				end
				default: state <= tlp_pkg::SLV_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tlp_cpl_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlp_cpl_framer (
	input  wire                     pcie_clk,
	input  wire                     sys_rst,
	input  wire [7:0]               bus_num_i,
	input  wire [4:0]               dev_num_i,
	input  wire [2:0]               func_num_i,
	input  wire                     tx_rdy_i,
	input  wire                     cpl_valid_i,
	input  wire tlp_pkg::tlp_len_t  cpl_len_i,
	input  wire tlp_pkg::bcount_t   bcount_i,
	input  wire tlp_pkg::req_id_t   req_id_i,
	input  wire tlp_pkg::tag_t      tag_i,
	input  wire tlp_pkg::low_addr_t low_addr_i,
	input  wire tlp_pkg::data16_t   slv_rdata_i,
	output logic                    tx_req_o,
	output logic                    tx_st_o,
	output logic                    tx_end_o,
	output tlp_pkg::data16_t        tx_data_o,
	output logic                    pay_req_o,
	output logic                    cpl_done_o
);

	tlp_pkg::tx_state_e state;
	logic [11:0]        cnt;
	logic [11:0]        pay_hw;
	logic [11:0]        last_idx;
	logic               req_win;
	tlp_pkg::data16_t   hdr_word;

	// Length zero stands for 1024 doublewords
	assign pay_hw   = {cpl_len_i == '0, cpl_len_i, 1'b0};
	assign last_idx = pay_hw + 12'd5;

	// Slave read data lags the request by three cycles
	assign req_win = cnt >= 12'd3 && cnt < pay_hw + 12'd3;

	always_comb begin
		case (cnt[2:0])
			3'd0: hdr_word = {1'b0, tlp_pkg::CPL_FMT, tlp_pkg::CPL_TYPE, 1'b0, 3'b000, 4'b0000};
			3'd1: hdr_word = {6'b000000, cpl_len_i};
			3'd2: hdr_word = {bus_num_i, dev_num_i, func_num_i};
			3'd3: hdr_word = {3'b000, 1'b0, bcount_i};
			3'd4: hdr_word = req_id_i;
			default: hdr_word = {tag_i, 1'b0, low_addr_i};
		endcase
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state      <= tlp_pkg::TX_IDLE;
			tx_req_o   <= 1'b0;
			tx_st_o    <= 1'b0;
			tx_end_o   <= 1'b0;
			pay_req_o  <= 1'b0;
			cpl_done_o <= 1'b0;
		end else begin
			tx_st_o    <= 1'b0;
			tx_end_o   <= 1'b0;
			pay_req_o  <= 1'b0;
			cpl_done_o <= 1'b0;
			case (state)
				tlp_pkg::TX_IDLE: begin
					// cpl_valid is still high in the cycle of cpl_done
					if (cpl_valid_i && !cpl_done_o) begin
						tx_req_o <= 1'b1;
						cnt      <= '0;
						state    <= tlp_pkg::TX_WAIT;
					end
				end
				tlp_pkg::TX_WAIT: begin
					if (tx_rdy_i) begin
						tx_req_o  <= 1'b0;
						tx_st_o   <= 1'b1;
						tx_data_o <= hdr_word;
						cnt       <= 12'd1;
						state     <= tlp_pkg::TX_HDR;
					end
				end
				tlp_pkg::TX_HDR: begin
					tx_data_o <= hdr_word;
					pay_req_o <= req_win;
					cnt       <= cnt + 12'd1;
					if (cnt == 12'd5)
						state <= tlp_pkg::TX_PAY;
				end
				tlp_pkg::TX_PAY: begin
					tx_data_o <= slv_rdata_i;
					pay_req_o <= req_win;
					cnt       <= cnt + 12'd1;
					if (cnt == last_idx) begin
						tx_end_o   <= 1'b1;
						cpl_done_o <= 1'b1;
						state      <= tlp_pkg::TX_IDLE;
					end
				end
				default: state <= tlp_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pcie_tlp.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcie_tlp #(
	parameter int SLV_ADR_W = 19
) (
	input  wire                    pcie_clk,
	input  wire                    sys_rst,
	input  wire tlp_pkg::bar_hit_t rx_bar_hit_i,
	input  wire [7:0]              bus_num_i,
	input  wire [4:0]              dev_num_i,
	input  wire [2:0]              func_num_i,
	input  wire                    rx_st_i,
	input  wire                    rx_end_i,
	input  wire tlp_pkg::data16_t  rx_data_i,
	output wire                    tx_req_o,
	input  wire                    tx_rdy_i,
	output wire                    tx_st_o,
	output wire                    tx_end_o,
	output wire tlp_pkg::data16_t  tx_data_o,
	output wire tlp_pkg::pd_num_t  pd_num_o,
	output wire                    ph_cr_o,
	output wire                    pd_cr_o,
	output wire                    nph_cr_o,
	output wire                    npd_cr_o,
	output wire tlp_pkg::bar_hit_t slv_bar_o,
	output wire                    slv_ce_o,
	output wire                    slv_we_o,
	output wire [SLV_ADR_W-1:0]    slv_adr_o,
	output wire tlp_pkg::data16_t  slv_dat_o,
	output wire [1:0]              slv_sel_o,
	input  wire tlp_pkg::data16_t  slv_rdata_i
);

	// ------------------------------
	// Parser outputs
	// ------------------------------
	wire                     hdr_valid;
	tlp_pkg::tlp_kind_e      rx_kind;
	wire                     has_data;
	tlp_pkg::tlp_len_t       length;
	tlp_pkg::req_id_t        req_id;
	tlp_pkg::tag_t           tag;
	tlp_pkg::byte_en_t       first_be;
	tlp_pkg::byte_en_t       last_be;
	wire [29:0]              addr;
	wire                     pay_valid;
	tlp_pkg::data16_t        pay_data;
	wire                     pay_end;

	// Completion between sequencer and framer
	wire                     cpl_valid;
	tlp_pkg::tlp_len_t       cpl_len;
	tlp_pkg::bcount_t        bcount;
	tlp_pkg::req_id_t        cpl_req_id;
	tlp_pkg::tag_t           cpl_tag;
	tlp_pkg::low_addr_t      low_addr;
	wire                     pay_req;
	wire                     cpl_done;

	tlp_rx_parser u_rx_parser (
		.pcie_clk    (pcie_clk),
		.sys_rst     (sys_rst),
		.rx_st_i     (rx_st_i),
		.rx_end_i    (rx_end_i),
		.rx_data_i   (rx_data_i),
		.hdr_valid_o (hdr_valid),
		.kind_o      (rx_kind),
		.has_data_o  (has_data),
		.addr64_o    (),
		.length_o    (length),
		.req_id_o    (req_id),
		.tag_o       (tag),
		.first_be_o  (first_be),
		.last_be_o   (last_be),
		.addr_o      (addr),
		.pay_valid_o (pay_valid),
		.pay_data_o  (pay_data),
		.pay_end_o   (pay_end)
	);

	tlp_rx_credit u_rx_credit (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_end_i     (rx_end_i),
		.rx_bar_hit_i (rx_bar_hit_i),
		.kind_i       (rx_kind),
		.has_data_i   (has_data),
		.length_i     (length),
		.ph_cr_o      (ph_cr_o),
		.pd_cr_o      (pd_cr_o),
		.nph_cr_o     (nph_cr_o),
		.npd_cr_o     (npd_cr_o),
		.pd_num_o     (pd_num_o)
	);

	slv_sequencer #(
		.SLV_ADR_W (SLV_ADR_W)
	) u_slv_seq (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.hdr_valid_i  (hdr_valid),
		.kind_i       (rx_kind),
		.has_data_i   (has_data),
		.length_i     (length),
		.req_id_i     (req_id),
		.tag_i        (tag),
		.first_be_i   (first_be),
		.last_be_i    (last_be),
		.addr_i       (addr),
		.pay_valid_i  (pay_valid),
		.pay_data_i   (pay_data),
		.pay_end_i    (pay_end),
		.rx_bar_hit_i (rx_bar_hit_i),
		.pay_req_i    (pay_req),
		.cpl_done_i   (cpl_done),
		.slv_bar_o    (slv_bar_o),
		.slv_ce_o     (slv_ce_o),
		.slv_we_o     (slv_we_o),
		.slv_adr_o    (slv_adr_o),
		.slv_dat_o    (slv_dat_o),
		.slv_sel_o    (slv_sel_o),
		.cpl_valid_o  (cpl_valid),
		.cpl_len_o    (cpl_len),
		.bcount_o     (bcount),
		.cpl_req_id_o (cpl_req_id),
		.cpl_tag_o    (cpl_tag),
		.low_addr_o   (low_addr)
	);

	tlp_cpl_framer u_cpl_framer (
		.pcie_clk    (pcie_clk),
		.sys_rst     (sys_rst),
		.bus_num_i   (bus_num_i),
		.dev_num_i   (dev_num_i),
		.func_num_i  (func_num_i),
		.tx_rdy_i    (tx_rdy_i),
		.cpl_valid_i (cpl_valid),
		.cpl_len_i   (cpl_len),
		.bcount_i    (bcount),
		.req_id_i    (cpl_req_id),
		.tag_i       (cpl_tag),
		.low_addr_i  (low_addr),
		.slv_rdata_i (slv_rdata_i),
		.tx_req_o    (tx_req_o),
		.tx_st_o     (tx_st_o),
		.tx_end_o    (tx_end_o),
		.tx_data_o   (tx_data_o),
		.pay_req_o   (pay_req),
		.cpl_done_o  (cpl_done)
	);

endmodule

`default_nettype wire

// ==== tb/tb_pcie_tlp.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_tlp;

	localparam int          SLV_ADR_W = 19;
	localparam int          MAX_ROWS  = 32;
	localparam logic [31:0] SEED      = 32'h3db7ba7e;

	logic                 pcie_clk;
	logic                 sys_rst;
	tlp_pkg::bar_hit_t    rx_bar_hit_i;
	logic [7:0]           bus_num_i;
	logic [4:0]           dev_num_i;
	logic [2:0]           func_num_i;
	logic                 rx_st_i;
	logic                 rx_end_i;
	tlp_pkg::data16_t     rx_data_i;
	logic                 tx_rdy_i;
	tlp_pkg::data16_t     slv_rdata_i;
	wire                  tx_req_o;
	wire                  tx_st_o;
	wire                  tx_end_o;
	wire tlp_pkg::data16_t tx_data_o;
	wire tlp_pkg::pd_num_t pd_num_o;
	wire                  ph_cr_o;
	wire                  pd_cr_o;
	wire                  nph_cr_o;
	wire                  npd_cr_o;
	wire tlp_pkg::bar_hit_t slv_bar_o;
	wire                  slv_ce_o;
	wire                  slv_we_o;
	wire [SLV_ADR_W-1:0]  slv_adr_o;
	wire tlp_pkg::data16_t slv_dat_o;
	wire [1:0]            slv_sel_o;

	integer            seed;
	int                errors;
	int                checks;
	int                wr_strobes;
	int                rd_strobes;
	tlp_pkg::bar_hit_t cur_bar;
	logic [7:0]        smem [0:4095];
	logic [7:0]        ref_mem [0:4095];
	tlp_pkg::data16_t  tlp_hw [0:63];
	int                n_hw;

	// ------------------------------
	// Stimulus table
	// ------------------------------
	int                 n_rows;
	tlp_pkg::tlp_kind_e t_kind [0:MAX_ROWS-1];
	logic               t_wr [0:MAX_ROWS-1];
	tlp_pkg::bar_hit_t  t_bar [0:MAX_ROWS-1];
	logic [31:0]        t_addr [0:MAX_ROWS-1];
	tlp_pkg::tlp_len_t  t_len [0:MAX_ROWS-1];
	tlp_pkg::byte_en_t  t_fbe [0:MAX_ROWS-1];
	tlp_pkg::byte_en_t  t_lbe [0:MAX_ROWS-1];
	logic [15:0]        t_seed [0:MAX_ROWS-1];
	logic [3:0]         t_cr [0:MAX_ROWS-1];
	tlp_pkg::pd_num_t   t_pdn [0:MAX_ROWS-1];
	tlp_pkg::bcount_t   t_bcount [0:MAX_ROWS-1];
	tlp_pkg::low_addr_t t_la [0:MAX_ROWS-1];

	pcie_tlp #(
		.SLV_ADR_W (SLV_ADR_W)
	) dut_i (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_bar_hit_i (rx_bar_hit_i),
		.bus_num_i    (bus_num_i),
		.dev_num_i    (dev_num_i),
		.func_num_i   (func_num_i),
		.rx_st_i      (rx_st_i),
		.rx_end_i     (rx_end_i),
		.rx_data_i    (rx_data_i),
		.tx_req_o     (tx_req_o),
		.tx_rdy_i     (tx_rdy_i),
		.tx_st_o      (tx_st_o),
		.tx_end_o     (tx_end_o),
		.tx_data_o    (tx_data_o),
		.pd_num_o     (pd_num_o),
		.ph_cr_o      (ph_cr_o),
		.pd_cr_o      (pd_cr_o),
		.nph_cr_o     (nph_cr_o),
		.npd_cr_o     (npd_cr_o),
		.slv_bar_o    (slv_bar_o),
		.slv_ce_o     (slv_ce_o),
		.slv_we_o     (slv_we_o),
		.slv_adr_o    (slv_adr_o),
		.slv_dat_o    (slv_dat_o),
		.slv_sel_o    (slv_sel_o),
		.slv_rdata_i  (slv_rdata_i)
	);

	initial begin
		pcie_clk = 1'b0;
		forever #20 pcie_clk = ~pcie_clk;
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	function automatic logic [7:0] fill_byte(input logic [11:0] a);
		return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'hC3;
	endfunction

	// PCIe type field per command class
	function automatic logic [4:0] type_code(input tlp_pkg::tlp_kind_e kind);
		case (kind)
			tlp_pkg::MEM:      return 5'b00000;
			tlp_pkg::MEM_LOCK: return 5'b00001;
			tlp_pkg::IO:       return 5'b00010;
			tlp_pkg::CFG0:     return 5'b00100;
			tlp_pkg::CFG1:     return 5'b00101;
			tlp_pkg::MSG:      return 5'b10000;
			tlp_pkg::CPL:      return 5'b01010;
			default:           return 5'b01011;
		endcase
	endfunction

	function automatic logic byte_enabled(input int r, input int j);
		int dw;
		dw = j / 4;
		if (dw == 0)
			return t_fbe[r][j % 4];
		if (dw == t_len[r] - 1)
			return t_lbe[r][j % 4];
		return 1'b1;
	endfunction

	task automatic add_row(input tlp_pkg::tlp_kind_e kind, input logic wr,
		input tlp_pkg::bar_hit_t bar, input logic [31:0] addr, input tlp_pkg::tlp_len_t len,
		input tlp_pkg::byte_en_t fbe, input tlp_pkg::byte_en_t lbe, input logic [15:0] dseed,
		input logic [3:0] cr, input tlp_pkg::pd_num_t pdn, input tlp_pkg::bcount_t bc,
		input tlp_pkg::low_addr_t la);
		t_kind[n_rows]   = kind;
		t_wr[n_rows]     = wr;
		t_bar[n_rows]    = bar;
		t_addr[n_rows]   = addr;
		t_len[n_rows]    = len;
		t_fbe[n_rows]    = fbe;
		t_lbe[n_rows]    = lbe;
		t_seed[n_rows]   = dseed;
		t_cr[n_rows]     = cr;
		t_pdn[n_rows]    = pdn;
		t_bcount[n_rows] = bc;
		t_la[n_rows]     = la;
		n_rows++;
	endtask

	task automatic push_hw(input tlp_pkg::data16_t hw);
		tlp_hw[n_hw] = hw;
		n_hw++;
	endtask

	// Header plus payload; memory writes with a BAR hit also update the expected memory
	task automatic build_tlp(input int r);
		logic [31:0] a;
		logic        wr_hit;
		integer      pay_seed;
		integer      rnd;
		int          base;
		int          j;
		a        = t_addr[r];
		base     = {a[11:2], 2'b00};
		wr_hit   = t_kind[r] == tlp_pkg::MEM && t_wr[r] && t_bar[r] != '0;
		pay_seed = SEED ^ t_seed[r];
		n_hw     = 0;
		push_hw({1'b0, t_wr[r], t_kind[r] == tlp_pkg::MSG, type_code(t_kind[r]), 8'h00});
		push_hw({6'b000000, t_len[r]});
		push_hw(16'h0100 + r[15:0]);
		push_hw({8'h20 + r[7:0], t_lbe[r], t_fbe[r]});
		if (t_kind[r] == tlp_pkg::MSG) begin
			push_hw(16'h0000);
			push_hw(16'h0000);
		end
		push_hw(a[31:16]);
		push_hw({a[15:2], 2'b00});
		for (j = 0; t_wr[r] && j < 4 * t_len[r]; j += 2) begin
			rnd = $random(pay_seed);
			push_hw(rnd[15:0]);
			if (wr_hit && byte_enabled(r, j))
				ref_mem[base + j] = rnd[15:8];
			if (wr_hit && byte_enabled(r, j + 1))
				ref_mem[base + j + 1] = rnd[7:0];
		end
	endtask

	task automatic drive_tlp(input int r);
		int i;
		for (i = 0; i < n_hw; i++) begin
			@(posedge pcie_clk);
			rx_st_i      <= (i == 0);
			rx_end_i     <= (i == n_hw - 1);
			rx_data_i    <= tlp_hw[i];
			rx_bar_hit_i <= t_bar[r];
		end
		@(posedge pcie_clk);
		rx_st_i      <= 1'b0;
		rx_end_i     <= 1'b0;
		rx_data_i    <= '0;
		rx_bar_hit_i <= '0;
	endtask

	task automatic collect_cpl(input int r);
		int               k;
		int               n;
		int               d;
		int               base;
		logic             seen;
		tlp_pkg::data16_t want;
		seen = 1'b0;
		for (k = 0; k < 20 && !seen; k++) begin
			@(negedge pcie_clk);
			seen = tx_req_o;
		end
		assert (seen) else note_failure("no transmit request for a read completion");
		// Grant held back for a few cycles
		d = 1 + {$random(seed)} % 6;
		for (k = 0; k < d && seen; k++) begin
			@(negedge pcie_clk);
			check_eq("tx_req_o", tx_req_o, 1'b1);
			check_eq("tx_st_o", tx_st_o, 1'b0);
		end
		@(posedge pcie_clk);
		tx_rdy_i <= seen;
		seen = 1'b0;
		for (k = 0; k < 10 && !seen; k++) begin
			@(negedge pcie_clk);
			seen = tx_st_o;
		end
		assert (seen) else note_failure("completion did not start after the grant");
		n    = 6 + 2 * t_len[r];
		base = {t_addr[r][11:2], 2'b00};
		for (k = 0; k < n && seen; k++) begin
			if (k > 0)
				@(negedge pcie_clk);
			case (k)
				0:       want = {1'b0, 2'b10, 5'b01010, 8'h00};
				1:       want = {6'b000000, t_len[r]};
				2:       want = {bus_num_i, dev_num_i, func_num_i};
				3:       want = {4'b0000, t_bcount[r]};
				4:       want = 16'h0100 + r[15:0];
				5:       want = {8'h20 + r[7:0], 1'b0, t_la[r]};
				default: want = {ref_mem[base + 2 * (k - 6)], ref_mem[base + 2 * (k - 6) + 1]};
			endcase
			check_eq($sformatf("tx_data_o[%0d]", k), tx_data_o, want);
			check_eq("tx_st_o", tx_st_o, k == 0);
			check_eq("tx_end_o", tx_end_o, k == n - 1);
		end
		@(posedge pcie_clk);
		tx_rdy_i <= 1'b0;
	endtask

	task automatic run_row(input int r);
		int         wr0;
		int         rd0;
		int         k;
		logic       hit;
		logic [3:0] cr;
		hit     = t_kind[r] == tlp_pkg::MEM && t_bar[r] != '0;
		cr      = t_cr[r];
		wr0     = wr_strobes;
		rd0     = rd_strobes;
		cur_bar = t_bar[r];
		build_tlp(r);
		drive_tlp(r);
		// Credits one cycle after the last halfword
		@(negedge pcie_clk);
		check_eq("ph_cr_o", ph_cr_o, cr[3]);
		check_eq("pd_cr_o", pd_cr_o, cr[2]);
		check_eq("nph_cr_o", nph_cr_o, cr[1]);
		check_eq("npd_cr_o", npd_cr_o, cr[0]);
		check_eq("pd_num_o", pd_num_o, t_pdn[r]);
		@(negedge pcie_clk);
		check_eq("credit outputs", {ph_cr_o, pd_cr_o, nph_cr_o, npd_cr_o}, 4'b0000);
		if (hit && !t_wr[r])
			collect_cpl(r);
		for (k = 0; k < 6; k++) begin
			@(negedge pcie_clk);
			check_eq("tx_req_o", tx_req_o, 1'b0);
			check_eq("tx_st_o", tx_st_o, 1'b0);
		end
		check_eq("write strobes", wr_strobes - wr0, (hit && t_wr[r]) ? 2 * t_len[r] : 0);
		check_eq("read strobes", rd_strobes - rd0, (hit && !t_wr[r]) ? 2 * t_len[r] : 0);
	endtask

	// ------------------------------
	// Slave memory model
	// ------------------------------
	always @(posedge pcie_clk) begin
		if (slv_ce_o) begin
			check_eq("slv_bar_o", slv_bar_o, cur_bar);
			assert (slv_adr_o < 2048) else note_failure("slave address outside the memory model");
			if (slv_we_o) begin
				wr_strobes <= wr_strobes + 1;
				if (slv_sel_o[1])
					smem[{slv_adr_o[10:0], 1'b0}] <= slv_dat_o[15:8];
				if (slv_sel_o[0])
					smem[{slv_adr_o[10:0], 1'b1}] <= slv_dat_o[7:0];
			end else begin
				rd_strobes  <= rd_strobes + 1;
				slv_rdata_i <= {smem[{slv_adr_o[10:0], 1'b0}], smem[{slv_adr_o[10:0], 1'b1}]};
			end
		end
	end

	initial begin
		int r;
		int i;
		sys_rst      = 1'b1;
		rx_bar_hit_i = '0;
		bus_num_i    = 8'h3A;
		dev_num_i    = 5'h11;
		func_num_i   = 3'h5;
		rx_st_i      = 1'b0;
		rx_end_i     = 1'b0;
		rx_data_i    = '0;
		tx_rdy_i     = 1'b0;
		slv_rdata_i  = '0;
		seed         = SEED;
		errors       = 0;
		checks       = 0;
		wr_strobes   = 0;
		rd_strobes   = 0;
		cur_bar      = '0;
		n_rows       = 0;
		for (i = 0; i < 4096; i++) begin
			smem[i]    = fill_byte(i[11:0]);
			ref_mem[i] = fill_byte(i[11:0]);
		end
		// kind, wr, bar, addr, len, fbe, lbe, seed, {ph,pd,nph,npd}, pd_num, bcount, low addr
		add_row(tlp_pkg::MEM,  1, 7'h01, 32'h100, 3, 4'hE, 4'h3, 16'h0011, 4'b1100, 1, 0, 0);
		add_row(tlp_pkg::MEM,  0, 7'h01, 32'h100, 3, 4'hE, 4'h3, 16'h0000, 4'b0010, 0, 9, 7'h01);
		add_row(tlp_pkg::MEM,  1, 7'h02, 32'h204, 5, 4'hF, 4'h8, 16'h0022, 4'b1100, 2, 0, 0);
		add_row(tlp_pkg::MEM,  0, 7'h02, 32'h204, 5, 4'h4, 4'hF, 16'h0000, 4'b0010, 0, 18, 7'h06);
		add_row(tlp_pkg::MEM,  0, 7'h01, 32'h108, 1, 4'h6, 4'h0, 16'h0000, 4'b0010, 0, 2, 7'h09);
		add_row(tlp_pkg::MEM,  0, 7'h01, 32'h03C, 1, 4'h0, 4'h0, 16'h0000, 4'b0010, 0, 1, 7'h3C);
		// No BAR hit
		add_row(tlp_pkg::MEM,  1, 7'h00, 32'h300, 2, 4'hF, 4'hF, 16'h0033, 4'b0000, 0, 0, 0);
		add_row(tlp_pkg::MEM,  0, 7'h00, 32'h300, 2, 4'hF, 4'hF, 16'h0000, 4'b0000, 0, 0, 0);
		add_row(tlp_pkg::MEM,  0, 7'h04, 32'h300, 2, 4'hF, 4'hF, 16'h0000, 4'b0010, 0, 8, 7'h00);
		add_row(tlp_pkg::MEM,  1, 7'h01, 32'h400, 8, 4'hF, 4'h7, 16'h0044, 4'b1100, 2, 0, 0);
		add_row(tlp_pkg::MEM,  0, 7'h01, 32'h400, 8, 4'hF, 4'hF, 16'h0000, 4'b0010, 0, 32, 7'h00);
		add_row(tlp_pkg::MEM,  1, 7'h01, 32'h500, 1, 4'h9, 4'h0, 16'h0055, 4'b1100, 1, 0, 0);
		add_row(tlp_pkg::MEM,  0, 7'h01, 32'h500, 1, 4'hF, 4'h0, 16'h0000, 4'b0010, 0, 4, 7'h00);
		// Credit only
		add_row(tlp_pkg::IO,   0, 7'h00, 32'h010, 1, 4'hF, 4'h0, 16'h0000, 4'b0010, 0, 0, 0);
		add_row(tlp_pkg::IO,   1, 7'h00, 32'h010, 1, 4'hF, 4'h0, 16'h0066, 4'b0011, 0, 0, 0);
		add_row(tlp_pkg::CFG0, 0, 7'h00, 32'h000, 1, 4'hF, 4'h0, 16'h0000, 4'b0010, 0, 0, 0);
		add_row(tlp_pkg::CFG1, 1, 7'h00, 32'h000, 1, 4'hF, 4'h0, 16'h0077, 4'b0011, 0, 0, 0);
		add_row(tlp_pkg::MSG,  0, 7'h00, 32'h000, 0, 4'h0, 4'h0, 16'h0000, 4'b1000, 0, 0, 0);
		add_row(tlp_pkg::MSG,  1, 7'h00, 32'h000, 6, 4'h0, 4'h0, 16'h0088, 4'b1100, 2, 0, 0);
		add_row(tlp_pkg::CPL,  1, 7'h00, 32'h000, 2, 4'h0, 4'h0, 16'h0099, 4'b0000, 0, 0, 0);
		add_row(tlp_pkg::CPL,  0, 7'h00, 32'h000, 0, 4'h0, 4'h0, 16'h0000, 4'b0000, 0, 0, 0);

		repeat (10) @(posedge pcie_clk);
		sys_rst <= 1'b0;
		@(negedge pcie_clk);
		check_eq("tx_req_o", tx_req_o, 1'b0);
		check_eq("tx_st_o", tx_st_o, 1'b0);
		check_eq("tx_end_o", tx_end_o, 1'b0);
		check_eq("credit outputs", {ph_cr_o, pd_cr_o, nph_cr_o, npd_cr_o}, 4'b0000);
		check_eq("pd_num_o", pd_num_o, 0);
		check_eq("slv_ce_o", slv_ce_o, 1'b0);
		check_eq("slv_we_o", slv_we_o, 1'b0);

		for (r = 0; r < n_rows; r++)
			run_row(r);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
common/tlp_pkg.sv
rx/tlp_rx_parser.sv
rx/tlp_rx_credit.sv
hdl/slv_sequencer.sv
hdl/tlp_cpl_framer.sv
hdl/pcie_tlp.sv
tb/tb_pcie_tlp.sv

// ==== Bender.yml ====
package:
  name: pcie_tlp

sources:
  - common/tlp_pkg.sv
  - rx/tlp_rx_parser.sv
  - rx/tlp_rx_credit.sv
  - hdl/slv_sequencer.sv
  - hdl/tlp_cpl_framer.sv
  - hdl/pcie_tlp.sv
  - target: test
    files:
      - tb/tb_pcie_tlp.sv
